/* design/bg_reg_pkg.sv */
package bg_reg_pkg;

  // register word index and contents
  typedef logic [3:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // word map: four control, four hofs, four vofs, then display enable
  localparam reg_addr_t REG_CNT_BASE  = 4'd0;
  localparam reg_addr_t REG_HOFS_BASE = 4'd4;
  localparam reg_addr_t REG_VOFS_BASE = 4'd8;
  localparam reg_addr_t REG_DISP      = 4'd12;

  // field types
  typedef logic [1:0] bg_prio_t;
  typedef logic [1:0] char_base_t;     // 16 KiB unit
  typedef logic [4:0] screen_base_t;   // 2 KiB unit
  typedef logic [8:0] scroll_t;        // low 8 bits matter, map is 256 wide

  // decoded view of one background
  typedef struct packed {
    bg_prio_t     bg_priority;
    char_base_t   char_base;
    logic         palette_mode;        // 1 = 256 colours
    screen_base_t screen_base;
    scroll_t      hofs;
    scroll_t      vofs;
    logic         enabled;
  } bg_cfg_t;

endpackage

/* design/bg_pix_pkg.sv */
package bg_pix_pkg;

  // scan geometry
  localparam int SCAN_COLS     = 308;
  localparam int SCAN_ROWS     = 228;
  localparam int VIS_COLS      = 240;
  localparam int VIS_ROWS      = 160;
  localparam int NUM_BG        = 4;
  localparam int FETCH_LATENCY = 3;   // scan slot to pixel_out

  typedef logic [1:0] bg_id_t;
  typedef logic [8:0] col_t;
  typedef logic [7:0] row_t;

  typedef struct packed {
    row_t   row;
    col_t   col;
    bg_id_t bg;
  } scan_pos_t;

  typedef logic [15:0] vram_addr_t;   // halfword address
  typedef logic [15:0] vram_data_t;
  typedef logic [7:0]  color_idx_t;
  typedef logic [3:0]  pal_bank_t;

  // record handed to the compositor
  typedef struct packed {
    scan_pos_t  pos;
    logic       used;
    logic       transparent;
    logic [1:0] bg_priority;
    color_idx_t color;
  } bg_pixel_t;

  // what the formatter needs alongside char_data
  typedef struct packed {
    scan_pos_t  pos;
    logic [1:0] bg_priority;
    logic       palette_mode;
    logic       enabled;
    logic [1:0] xx_lo;               // flipped xx mod 4
    pal_bank_t  bank;
  } stage2_ctx_t;

endpackage

/* design/bg_regs.sv */
`timescale 1ns/1ns

module bg_regs (
  input  logic                                          clock,
  input  logic                                          rst_n,
  input  logic                                          reg_we,
  input  bg_reg_pkg::reg_addr_t                         reg_addr,
  input  bg_reg_pkg::reg_data_t                         reg_wdata,
  output bg_reg_pkg::bg_cfg_t [bg_pix_pkg::NUM_BG-1:0] bg_cfg
);
  import bg_reg_pkg::*;
  import bg_pix_pkg::*;

  reg_data_t cnt_q  [NUM_BG];
  reg_data_t hofs_q [NUM_BG];
  reg_data_t vofs_q [NUM_BG];
  reg_data_t disp_q;

  reg_addr_t cnt_off, hofs_off, vofs_off;

  // offsets below a base wrap to large values and miss
  assign cnt_off  = reg_addr - REG_CNT_BASE;
  assign hofs_off = reg_addr - REG_HOFS_BASE;
  assign vofs_off = reg_addr - REG_VOFS_BASE;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BG; i++) begin
        cnt_q[i]  <= '0;
        hofs_q[i] <= '0;
        vofs_q[i] <= '0;
      end
      disp_q <= '0;
    end else if (reg_we) begin
      if (cnt_off < NUM_BG)
        cnt_q[cnt_off[1:0]] <= reg_wdata;
      else if (hofs_off < NUM_BG)
        hofs_q[hofs_off[1:0]] <= reg_wdata;
      else if (vofs_off < NUM_BG)
        vofs_q[vofs_off[1:0]] <= reg_wdata;
      else if (reg_addr == REG_DISP)
        disp_q <= reg_wdata;   // mode bits kept but not decoded
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_BG; i++) begin
      bg_cfg[i].bg_priority  = cnt_q[i][1:0];
      bg_cfg[i].char_base    = cnt_q[i][3:2];
      bg_cfg[i].palette_mode = cnt_q[i][7];
      bg_cfg[i].screen_base  = cnt_q[i][12:8];
      bg_cfg[i].hofs         = hofs_q[i][8:0];
      bg_cfg[i].vofs         = vofs_q[i][8:0];
      bg_cfg[i].enabled      = disp_q[8 + i];
    end
  end

endmodule

/* design/bg_scan_counter.sv */
`timescale 1ns/1ns

module bg_scan_counter (
  input  logic                  clock,
  input  logic                  rst_n,
  output bg_pix_pkg::scan_pos_t pos,
  output logic                  frame_start
);
  import bg_pix_pkg::*;

  logic last_slot, last_col, last_row;

  assign last_slot = (pos.bg == bg_id_t'(NUM_BG - 1));
  assign last_col  = (pos.col == col_t'(SCAN_COLS - 1));
  assign last_row  = (pos.row == row_t'(SCAN_ROWS - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pos         <= '0;
      frame_start <= 1'b0;
    end else begin
      // high while slot 0 of row 0 col 0 is current
      frame_start <= last_slot && last_col && last_row;

      pos.bg <= last_slot ? '0 : pos.bg + 1'b1;
      if (last_slot) begin
        pos.col <= last_col ? '0 : pos.col + 1'b1;
        if (last_col)
          pos.row <= last_row ? '0 : pos.row + 1'b1;
      end
    end
  end

endmodule

/* design/bg_fetch_pipe.sv */
`timescale 1ns/1ns

module bg_fetch_pipe (
  input  logic                                          clock,
  input  logic                                          rst_n,
  input  bg_pix_pkg::scan_pos_t                         pos,
  input  bg_reg_pkg::bg_cfg_t [bg_pix_pkg::NUM_BG-1:0] bg_cfg,
  input  bg_pix_pkg::vram_data_t                        screen_data,
  output bg_pix_pkg::vram_addr_t                        screen_addr,
  output bg_pix_pkg::vram_addr_t                        char_addr,
  output bg_pix_pkg::stage2_ctx_t                       stage2_ctx
);
  import bg_reg_pkg::*;
  import bg_pix_pkg::*;

  // slot context between screen fetch and char fetch
  typedef struct packed {
    scan_pos_t  pos;
    bg_prio_t   bg_priority;
    logic       palette_mode;
    logic       enabled;
    char_base_t char_base;
    logic [2:0] xx;
    logic [2:0] yy;
  } stage1_ctx_t;

  bg_cfg_t     cfg;
  logic [7:0]  x, y;
  stage1_ctx_t ctx1;

  logic [9:0]  tile;
  logic        hflip, vflip;
  logic [2:0]  xx, yy;

  // stage 0: scrolled map coordinates of the current slot
  assign cfg = bg_cfg[pos.bg];
  assign x   = pos.col[7:0] + cfg.hofs[7:0];
  assign y   = pos.row + cfg.vofs[7:0];

  // base*1024 + ty*32 + tx, fields do not overlap
  assign screen_addr = {1'b0, cfg.screen_base, y[7:3], x[7:3]};

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ctx1 <= '0;
    end else begin
      ctx1.pos          <= pos;
      ctx1.bg_priority  <= cfg.bg_priority;
      ctx1.palette_mode <= cfg.palette_mode;
      ctx1.enabled      <= cfg.enabled;
      ctx1.char_base    <= cfg.char_base;
      ctx1.xx           <= x[2:0];
      ctx1.yy           <= y[2:0];
    end
  end

  // stage 1: screen entry is on screen_data now
  assign tile  = screen_data[9:0];
  assign hflip = screen_data[10];
  assign vflip = screen_data[11];
  assign xx    = hflip ? ~ctx1.xx : ctx1.xx;   // 7 - xx
  assign yy    = vflip ? ~ctx1.yy : ctx1.yy;

  always_comb begin
    if (ctx1.palette_mode)
      char_addr = {1'b0, ctx1.char_base, 13'd0} + {1'b0, tile, yy, xx[2:1]};   // 32 hw/tile
    else
      char_addr = {1'b0, ctx1.char_base, 13'd0} + {2'b0, tile, yy, xx[2]};     // 16 hw/tile
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      stage2_ctx <= '0;
    end else begin
      stage2_ctx.pos          <= ctx1.pos;
      stage2_ctx.bg_priority  <= ctx1.bg_priority;
      stage2_ctx.palette_mode <= ctx1.palette_mode;
      stage2_ctx.enabled      <= ctx1.enabled;
      stage2_ctx.xx_lo        <= xx[1:0];
      stage2_ctx.bank         <= screen_data[15:12];
    end
  end

endmodule

/* design/bg_pixel_formatter.sv */
`timescale 1ns/1ns

module bg_pixel_formatter (
  input  logic                    clock,
  input  logic                    rst_n,
  input  bg_pix_pkg::stage2_ctx_t stage2_ctx,
  input  bg_pix_pkg::vram_data_t  char_data,
  output bg_pix_pkg::bg_pixel_t   pixel_out
);
  import bg_pix_pkg::*;

  logic [3:0] nibble;
  logic [7:0] pix_byte;
  color_idx_t color;
  logic       is_zero;
  logic       visible;
  logic       used;

  // lowest nibble / low byte is the leftmost pixel
  assign nibble   = char_data[{stage2_ctx.xx_lo, 2'b00} +: 4];
  assign pix_byte = char_data[{stage2_ctx.xx_lo[0], 3'b000} +: 8];

  always_comb begin
    if (stage2_ctx.palette_mode) begin
      color   = pix_byte;
      is_zero = (pix_byte == '0);
    end else begin
      color   = {stage2_ctx.bank, nibble};
      is_zero = (nibble == '0);
    end
  end

  assign visible = (stage2_ctx.pos.col < col_t'(VIS_COLS)) &&
                   (stage2_ctx.pos.row < row_t'(VIS_ROWS));
  assign used    = stage2_ctx.enabled && visible;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pixel_out <= '0;
    end else begin
      pixel_out.pos         <= stage2_ctx.pos;
      pixel_out.used        <= used;
      pixel_out.bg_priority <= stage2_ctx.bg_priority;
      // unused slots read as empty
      pixel_out.transparent <= is_zero || !used;
      pixel_out.color       <= used ? color : '0;
    end
  end

endmodule

/* design/bg_engine.sv */
`timescale 1ns/1ns

module bg_engine (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   reg_we,
  input  bg_reg_pkg::reg_addr_t  reg_addr,
  input  bg_reg_pkg::reg_data_t  reg_wdata,
  input  bg_pix_pkg::vram_data_t screen_data,
  input  bg_pix_pkg::vram_data_t char_data,
  output bg_pix_pkg::vram_addr_t screen_addr,
  output bg_pix_pkg::vram_addr_t char_addr,
  output bg_pix_pkg::bg_pixel_t  pixel_out,
  output logic                   frame_start
);
  import bg_reg_pkg::*;
  import bg_pix_pkg::*;

  bg_cfg_t [NUM_BG-1:0] bg_cfg;
  scan_pos_t            pos;
  stage2_ctx_t          stage2_ctx;

  bg_regs regs_i (
    .clock,
    .rst_n,
    .reg_we,
    .reg_addr,
    .reg_wdata,
    .bg_cfg
  );

  bg_scan_counter scan_i (
    .clock,
    .rst_n,
    .pos,
    .frame_start
  );

  // screen fetch, then char fetch, one VRAM cycle each
  bg_fetch_pipe fetch_i (
    .clock,
    .rst_n,
    .pos,
    .bg_cfg,
    .screen_data,
    .screen_addr,
    .char_addr,
    .stage2_ctx
  );

  bg_pixel_formatter fmt_i (
    .clock,
    .rst_n,
    .stage2_ctx,
    .char_data,
    .pixel_out
  );

endmodule

/* tests/bg_engine_assert.sv */
`timescale 1ns/1ns

module bg_engine_assert (
  input logic                  clock,
  input logic                  rst_n,
  input bg_pix_pkg::bg_pixel_t pixel_out,
  input logic                  frame_start
);
  import bg_pix_pkg::*;

  int fail_cnt = 0;   // failed assertions so far

  // pipeline still carries reset contexts
  quiet_after_reset: assert property (@(posedge clock)
    $rose(rst_n) |-> !pixel_out.used [*FETCH_LATENCY])
    else begin
      fail_cnt++;
      $error("pixel_out.used set while the pipeline was filling");
    end

  bg_steps: assert property (@(posedge clock) disable iff (!rst_n)
    $past(rst_n, FETCH_LATENCY + 1) |->
      pixel_out.pos.bg == bg_id_t'($past(pixel_out.pos.bg) + 1'b1))
    else begin
      fail_cnt++;
      $error("pixel_out.pos.bg did not advance by one");
    end

  used_visible: assert property (@(posedge clock) disable iff (!rst_n)
    pixel_out.used |->
      (pixel_out.pos.col < col_t'(VIS_COLS)) && (pixel_out.pos.row < row_t'(VIS_ROWS)))
    else begin
      fail_cnt++;
      $error("pixel_out.used outside the visible area");
    end

  frame_pulse: assert property (@(posedge clock) disable iff (!rst_n)
    frame_start |=> !frame_start)
    else begin
      fail_cnt++;
      $error("frame_start longer than one cycle");
    end

endmodule

bind bg_engine bg_engine_assert assert_i (
  .clock,
  .rst_n,
  .pixel_out,
  .frame_start
);

/* tests/bg_engine_tb.sv */
`timescale 1ns/1ns

module bg_engine_tb;
  import bg_reg_pkg::*;
  import bg_pix_pkg::*;

  localparam int FRAME_CYCLES = SCAN_COLS * SCAN_ROWS * NUM_BG;

  logic        clock = 1'b0;
  logic        rst_n = 1'b0;
  logic        reg_we = 1'b0;
  reg_addr_t   reg_addr = '0;
  reg_data_t   reg_wdata = '0;
  vram_data_t  screen_data = '0;
  vram_data_t  char_data = '0;
  vram_addr_t  screen_addr, char_addr;
  vram_addr_t  screen_addr_q = '0;
  vram_addr_t  char_addr_q = '0;
  vram_addr_t  char_hist = '0;
  bg_pixel_t   pixel_out;
  logic        frame_start;

  reg_data_t   shadow [16];      // register words as written
  vram_addr_t  addr_hist [3];    // stage-0 addresses with the newest first
  byte         kind_q [$];
  logic [19:0] wr_q [$];
  bg_pixel_t   probe_q [$];
  int          groups = 0;
  int          cycles = 0;
  int          limit = FRAME_CYCLES;

  bg_engine dut_i (.*);

  always #5 clock = ~clock;

  // VRAM model
  always @(posedge clock) begin
    screen_addr_q <= screen_addr;
    char_addr_q   <= char_addr;
    char_hist     <= char_addr_q;   // char address of the slot now on pixel_out
  end

  always @(negedge clock) begin
    screen_data  <= screen_addr_q;                          // entry is its own address
    char_data    <= {char_addr_q[7:0], char_addr_q[15:8]};  // bytes swapped
    addr_hist[0] <= screen_addr;
    addr_hist[1] <= addr_hist[0];
    addr_hist[2] <= addr_hist[1];
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= limit)
      abort_run("timeout, not every probe was matched before the cycle limit");
    else if (dut_i.assert_i.fail_cnt != 0)
      abort_run("a bound assertion on bg_engine failed");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_pixel(input bg_pixel_t exp, input bg_pixel_t act);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t ns: pixel_out expected %h, got %h",
                          $time, exp, act));
  endtask

  task automatic check_addr(input string name, input vram_addr_t exp,
                            input vram_addr_t act);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t ns: %s expected %h, got %h",
                          $time, name, exp, act));
  endtask

  task automatic check_pos(input scan_pos_t exp, input scan_pos_t act);
    if (act !== exp)
      abort_run($sformatf("** Error at %0t ns: pixel_out.pos after frame_start expected %h, got %h",
                          $time, exp, act));
  endtask

  // map entry address for a slot from the written registers
  function automatic vram_addr_t expected_screen_addr(input scan_pos_t p);
    int x, y;
    int base;
    base = shadow[REG_CNT_BASE + p.bg][12:8];
    x = (p.col + shadow[REG_HOFS_BASE + p.bg]) % 256;
    y = (p.row + shadow[REG_VOFS_BASE + p.bg]) % 256;
    return vram_addr_t'(base * 1024 + (y / 8) * 32 + x / 8);
  endfunction

  // char address for a slot, the map entry being its own address
  function automatic vram_addr_t expected_char_addr(input scan_pos_t p);
    vram_addr_t entry;
    reg_data_t  cnt;
    int         xx, yy;
    int         base;
    entry = expected_screen_addr(p);
    cnt   = shadow[REG_CNT_BASE + p.bg];
    xx    = (p.col + shadow[REG_HOFS_BASE + p.bg]) % 8;
    yy    = (p.row + shadow[REG_VOFS_BASE + p.bg]) % 8;
    if (entry[10])
      xx = 7 - xx;
    if (entry[11])
      yy = 7 - yy;
    base = cnt[3:2] * 8192;
    if (cnt[7])
      return vram_addr_t'(base + entry[9:0] * 32 + yy * 4 + xx / 2);
    else
      return vram_addr_t'(base + entry[9:0] * 16 + yy * 2 + xx / 4);
  endfunction

  task automatic read_tests();
    int          fd;
    int          r, c, b, u, t, p;
    logic [15:0] a, d, clr;
    string       line;
    bg_pixel_t   px;
    fd = $fopen("tests/bg_engine_tests.txt", "r");
    if (fd == 0)
      abort_run("cannot open tests/bg_engine_tests.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] == "W") begin
        void'($sscanf(line, "W %h %h", a, d));
        wr_q.push_back({a[3:0], d});
        kind_q.push_back("W");
      end else if (line.len() > 0 && line[0] == "P") begin
        void'($sscanf(line, "P %d %d %d %d %d %d %h", r, c, b, u, t, p, clr));
        px.pos.row      = row_t'(r);
        px.pos.col      = col_t'(c);
        px.pos.bg       = bg_id_t'(b);
        px.used         = u[0];
        px.transparent  = t[0];
        px.bg_priority  = p[1:0];
        px.color        = clr[7:0];
        probe_q.push_back(px);
        kind_q.push_back("P");
      end else if (line.len() > 0 && line[0] == "E") begin
        groups++;
        kind_q.push_back("E");
      end
    end
    $fclose(fd);
  endtask

  task automatic write_reg(input reg_addr_t a, input reg_data_t d);
    @(negedge clock);
    reg_we    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge clock);
    reg_we    = 1'b0;
    shadow[a] = d;
  endtask

  // probes of one group in the frame after the next frame_start
  task automatic run_group(input int n);
    bg_pixel_t exp;
    do @(negedge clock); while (!frame_start);
    repeat (FETCH_LATENCY) @(negedge clock);
    check_pos(scan_pos_t'(0), pixel_out.pos);   // first slot of the frame
    repeat (n) begin
      exp = probe_q.pop_front();
      while (pixel_out.pos != exp.pos)
        @(negedge clock);
      check_pixel(exp, pixel_out);
      check_addr("screen_addr", expected_screen_addr(exp.pos), addr_hist[2]);  // three slots back
      check_addr("char_addr", expected_char_addr(exp.pos), char_hist);
    end
  endtask

  initial begin
    byte         kind;
    logic [19:0] wr;
    int          pending;
    pending = 0;
    for (int i = 0; i < 16; i++)
      shadow[i] = '0;
    read_tests();
    limit = (groups + 1) * FRAME_CYCLES;
    repeat (2) @(negedge clock);
    rst_n = 1'b1;
    while (kind_q.size() > 0) begin
      kind = kind_q.pop_front();
      if (kind == "W") begin
        wr = wr_q.pop_front();
        write_reg(wr[19:16], wr[15:0]);
      end else if (kind == "P") begin
        pending++;
      end else begin
        run_group(pending);
        pending = 0;
      end
    end
    if (dut_i.assert_i.fail_cnt != 0) begin
      abort_run("a bound assertion on bg_engine failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* tests/bg_engine_tests.txt */
# W reg_index(hex) data(hex) is a register write, landing before the next frame_start
# P row col bg used transparent priority color(hex) is an expected record in scan order, E ends a group
P 0 0 0 0 1 0 00
P 10 5 2 0 1 0 00
P 200 300 1 0 1 0 00
E
W 0 0505
W 1 0A8A
W 2 0303
W 4 01F8
W 6 0003
W 8 000C
W 9 0064
W A 0105
W C 0703
W F FFFF
P 3 65 1 1 1 2 00
P 20 10 0 1 0 1 12
P 20 10 1 1 0 2 7c
P 20 10 2 1 0 3 0c
P 20 10 3 0 1 0 00
P 20 13 0 1 1 1 10
P 159 239 1 1 0 2 b3
P 159 240 0 0 1 1 00
E
W 0 0080
W 4 0021
W C 0100
P 20 10 0 1 0 0 a1
P 20 10 2 0 1 3 00
P 100 230 0 1 0 0 03
E

/* bg_engine.f */
design/bg_reg_pkg.sv
design/bg_pix_pkg.sv
design/bg_regs.sv
design/bg_scan_counter.sv
design/bg_fetch_pipe.sv
design/bg_pixel_formatter.sv
design/bg_engine.sv
tests/bg_engine_assert.sv
tests/bg_engine_tb.sv
